// ==== mem_subsys.f ====
src/mem_pkg.sv
src/ram_bus_if.sv
src/ram_ctl.sv
src/work_ram.sv
src/mem_subsys.sv
verif/mem_subsys_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the memory subsystem testbench with Verilator and runs it.
# Exits non-zero unless the run reports a pass.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module mem_subsys_tb -f mem_subsys.f \
    && ./obj_dir/Vmem_subsys_tb | tee /dev/stderr | grep -q "Test passed" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== src/mem_pkg.sv ====
// Shared types for the CPU memory side.
// Addresses are byte addresses and the RAM bus is 16 bits wide, little-endian.
// Every design file pulls these in with a wildcard import.

package mem_pkg;

    typedef logic [23:0] addr_t;  // cpu byte address
    typedef logic [15:0] word_t;  // ram bus word
    typedef logic [31:0] long_t;  // store value and read window

    // one-hot store size, bit 0 byte, bit 1 word, bit 2 long
    typedef logic [2:0] size_t;

    // byte lane enable, bit 0 is the even byte
    typedef logic [1:0] be_t;

    localparam be_t be_none = 2'b00;
    localparam be_t be_lo   = 2'b01;  // even address byte
    localparam be_t be_hi   = 2'b10;  // odd address byte
    localparam be_t be_both = 2'b11;

endpackage

// ==== src/mem_subsys.sv ====
// Memory subsystem top level.
// Connects the RAM controller to the work RAM over the internal RAM bus
// and exposes the CPU side strobes, addresses and data as plain ports.
// addr_bits sets the RAM depth in words.

`timescale 1ns/1ps

module mem_subsys #(
    parameter int addr_bits = 10
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           cen,
    input  logic           ldram_en,
    input  mem_pkg::addr_t idx_addr,
    input  mem_pkg::addr_t xsp,
    input  mem_pkg::addr_t pc,
    input  logic           sel_xsp,
    input  logic           data_sel,
    input  mem_pkg::long_t alu_dout,
    input  logic           idx_wr,
    input  mem_pkg::size_t len,
    output mem_pkg::long_t dout,
    output logic           ram_rdy
);

    ram_bus_if ram_bus_i ();

    ram_ctl ram_ctl_i (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .ldram_en (ldram_en),
        .sel_xsp  (sel_xsp),
        .data_sel (data_sel),
        .idx_wr   (idx_wr),
        .idx_addr (idx_addr),
        .xsp      (xsp),
        .pc       (pc),
        .alu_dout (alu_dout),
        .len      (len),
        .bus      (ram_bus_i),
        .dout     (dout),
        .ram_rdy  (ram_rdy)
    );

    work_ram #(
        .addr_bits (addr_bits)
    ) work_ram_i (
        .clk (clk),
        .bus (ram_bus_i)
    );

endmodule

// ==== src/ram_bus_if.sv ====
// 16-bit RAM bus between the RAM controller and the work RAM.
// No handshake. dout follows addr combinationally, and the RAM
// writes the enabled lanes on each clock edge while we is non-zero.

`timescale 1ns/1ps

interface ram_bus_if;

    import mem_pkg::*;

    addr_t addr;  // full byte address, ram decodes the word part
    word_t din;
    be_t   we;    // per lane write enable
    word_t dout;

    modport ctl (
        output addr,
        output din,
        output we,
        input  dout
    );

    modport mem (
        input  addr,
        input  din,
        input  we,
        output dout
    );

endinterface

// ==== src/ram_ctl.sv ====
// RAM controller for the CPU core.
// Keeps a four byte read window that serves instruction fetch at pc and
// indexed loads at idx_addr. Forward moves of one to three bytes slide the
// window and fetch only the missing bytes. Indexed stores are split into
// one to three bus cycles with byte lane enables, and every store empties
// the window. All state advances on cen cycles only.

`timescale 1ns/1ps

module ram_ctl (
    input  logic           clk,
    input  logic           rst,
    input  logic           cen,
    input  logic           ldram_en,
    input  logic           sel_xsp,
    input  logic           data_sel,
    input  logic           idx_wr,
    input  mem_pkg::addr_t idx_addr,
    input  mem_pkg::addr_t xsp,
    input  mem_pkg::addr_t pc,
    input  mem_pkg::long_t alu_dout,
    input  mem_pkg::size_t len,
    ram_bus_if.ctl         bus,
    output mem_pkg::long_t dout,
    output logic           ram_rdy
);

    import mem_pkg::*;

    addr_t      req_addr;
    addr_t      eff_addr;
    long_t      eff_data;

    // read window
    addr_t      win_addr;      // address of window byte 0
    long_t      win_q;         // byte k holds win_addr + k
    logic [3:0] win_ok;
    logic [3:0] pend;          // bytes still to fetch
    logic [3:0] fetch_hit;
    logic [7:0] fetch_byte [4];
    addr_t      step;
    logic [1:0] shift;
    logic [3:0] keep_mask;

    // store sequencer
    logic [1:0] wr_step;       // 0 idle, 1 second cycle, 2 third cycle
    logic [1:0] st_next;
    addr_t      st_addr;
    word_t      st_din;
    be_t        st_we;

    logic       wr_active;
    logic       fetching;
    logic       win_hit;
    logic       can_slide;
    logic       slide_go;
    logic       reload_go;

    assign req_addr = ldram_en ? idx_addr : pc;
    assign eff_addr = sel_xsp ? xsp : idx_addr;
    assign eff_data = data_sel ? {8'd0, pc} : alu_dout;

    assign wr_active = idx_wr || wr_step != 2'd0;
    assign win_hit   = (&win_ok) && win_addr == req_addr;
    assign step      = req_addr - win_addr;
    assign shift     = step[1:0];
    assign keep_mask = 4'hf >> shift;
    assign can_slide = (&win_ok) && step != 24'd0 && step < 24'd4;

    // read side only runs when no store is in flight
    assign fetching  = !wr_active && pend != 4'd0;
    assign slide_go  = !wr_active && pend == 4'd0 && !win_hit && can_slide;
    assign reload_go = !wr_active && pend == 4'd0 && !win_hit && !can_slide;

    assign dout    = win_q;
    assign ram_rdy = win_hit && !wr_active;

    // match pending window bytes against the word now on the bus
    always_comb begin
        addr_t byte_a;
        for (int k = 0; k < 4; k++) begin
            byte_a        = win_addr + addr_t'(k);
            fetch_hit[k]  = pend[k] && (byte_a[23:1] == bus.addr[23:1]);
            fetch_byte[k] = byte_a[0] ? bus.dout[15:8] : bus.dout[7:0];
        end
    end

    // lane data for the current store cycle
    always_comb begin
        st_addr = (wr_step == 2'd0) ? eff_addr : bus.addr + 24'd2;
        st_din  = eff_data[15:0];
        st_we   = be_both;
        st_next = 2'd0;
        case (wr_step)
            2'd0: begin
                if (len[0] || eff_addr[0]) begin
                    st_din = {2{eff_data[7:0]}};  // lone byte on both lanes
                end
                if (len[0]) begin
                    st_we = eff_addr[0] ? be_hi : be_lo;
                end else if (eff_addr[0]) begin
                    st_we   = be_hi;
                    st_next = 2'd1;
                end else if (len[2]) begin
                    st_next = 2'd1;
                end
            end
            2'd1: begin
                if (!eff_addr[0]) begin
                    st_din = eff_data[31:16];  // upper half of an even long
                end else if (len[1]) begin
                    st_din = {2{eff_data[15:8]}};
                    st_we  = be_lo;
                end else begin
                    st_din  = eff_data[23:8];
                    st_next = 2'd2;
                end
            end
            2'd2: begin
                st_din = {2{eff_data[31:24]}};  // last byte of an odd long
                st_we  = be_lo;
            end
            default: begin
                st_we = be_none;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bus.addr <= '0;
            bus.din  <= '0;
            bus.we   <= be_none;
            wr_step  <= 2'd0;
            win_addr <= '0;
            win_ok   <= 4'd0;
            pend     <= 4'd0;
        end else if (cen) begin
            bus.we <= be_none;
            if (wr_active) begin
                bus.addr <= st_addr;
                bus.din  <= st_din;
                bus.we   <= st_we;
                wr_step  <= st_next;
                win_ok   <= 4'd0;  // stale after any store
                pend     <= 4'd0;
            end else if (fetching) begin
                bus.addr <= bus.addr + 24'd2;
                win_ok   <= win_ok | fetch_hit;
                pend     <= pend & ~fetch_hit;
            end else if (slide_go) begin
                win_addr <= req_addr;
                win_ok   <= keep_mask;
                pend     <= ~keep_mask;
                bus.addr <= win_addr + 24'd4;  // first byte past the old window
            end else if (reload_go) begin
                win_addr <= req_addr;
                win_ok   <= 4'd0;
                pend     <= 4'hf;
                bus.addr <= req_addr;
            end
        end
    end

    // window bytes
    always_ff @(posedge clk) begin
        if (cen) begin
            if (fetching) begin
                for (int k = 0; k < 4; k++) begin
                    if (fetch_hit[k]) begin
                        win_q[8*k +: 8] <= fetch_byte[k];
                    end
                end
            end else if (slide_go) begin
                win_q <= win_q >> {shift, 3'b000};  // drop the bytes left behind
            end
        end
    end

endmodule

// ==== src/work_ram.sv ====
// Work RAM for the CPU memory side.
// 16-bit words indexed by the word part of the byte address. Reads are
// asynchronous and writes land on the clock edge, each byte lane under
// its own enable. Contents are undefined until written.

`timescale 1ns/1ps

module work_ram #(
    parameter int addr_bits = 10  // word address bits
) (
    input  logic   clk,
    ram_bus_if.mem bus
);

    import mem_pkg::*;

    word_t                mem_q [2**addr_bits];
    logic [addr_bits-1:0] word_addr;

    assign word_addr = bus.addr[addr_bits:1];  // bit 0 picks the lane, not the word
    assign bus.dout  = mem_q[word_addr];

    always_ff @(posedge clk) begin
        if (bus.we[0]) begin
            mem_q[word_addr][7:0] <= bus.din[7:0];
        end
        if (bus.we[1]) begin
            mem_q[word_addr][15:8] <= bus.din[15:8];  // odd byte
        end
    end

endmodule

// ==== verif/mem_subsys_stim.txt ====
# op addr data len sel_xsp data_sel expect, all fields hex
# op W store, R data read at idx_addr, F fetch at pc; data is pc when data_sel is set
W 000000 33221100 4 0 0 00000000
W 000004 77665544 4 0 0 00000000
W 000008 BBAA9988 4 0 0 00000000
W 00000C FFEEDDCC 4 0 0 00000000
W 000010 13121110 4 0 0 00000000
W 000014 17161514 4 0 0 00000000
W 000080 8D8C8B8A 4 0 0 00000000
W 000084 91908F8E 4 0 0 00000000
R 000000 00000000 4 0 0 33221100
R 000001 00000000 4 0 0 44332211
W 000002 000000A5 1 0 0 00000000
R 000000 00000000 4 0 0 33A51100
W 000005 0000005A 1 0 0 00000000
R 000004 00000000 4 0 0 77665A44
W 000008 0000C3D2 2 0 0 00000000
R 000008 00000000 4 0 0 BBAAC3D2
W 00000B 0000E1F0 2 0 0 00000000
R 00000B 00000000 4 0 0 EEDDE1F0
W 00000D 04030201 4 0 0 00000000
R 00000D 00000000 4 0 0 04030201
F 000000 00000000 4 0 0 33A51100
F 000001 00000000 4 0 0 4433A511
F 000003 00000000 4 0 0 665A4433
F 000006 00000000 4 0 0 C3D27766
F 000007 00000000 4 0 0 AAC3D277
F 000009 00000000 4 0 0 E1F0AAC3
F 00000C 00000000 4 0 0 030201E1
F 000081 00000000 4 0 0 8E8D8C8B
W 000100 00ABCDEF 4 1 1 00000000
R 000100 00000000 4 0 0 00ABCDEF
W 000105 00123456 4 1 1 00000000
R 000105 00000000 4 0 0 00123456
F 000010 00000000 4 0 0 13121104
W 000011 000000EE 1 0 0 00000000
F 000010 00000000 4 0 0 1312EE04
R 000011 00000000 4 0 0 141312EE

// ==== verif/mem_subsys_tb.sv ====
// Testbench for the memory subsystem.
// Reads operations from the stim file. Each one is a store, a data read or a
// fetch, driven through the CPU side ports, and every read is checked against
// the expected data from the file. The file runs twice, once with cen held
// high and once with random cen stalls. Both runs must give the same data.

`timescale 1ns/1ps

module mem_subsys_tb;

    import mem_pkg::*;

    localparam int wait_limit = 200;  // cycles before any wait gives up

    logic  clk;
    logic  rst;
    logic  cen;
    logic  ldram_en;
    addr_t idx_addr;
    addr_t xsp;
    addr_t pc;
    logic  sel_xsp;
    logic  data_sel;
    long_t alu_dout;
    logic  idx_wr;
    size_t len;
    long_t dout;
    logic  ram_rdy;

    integer seed;
    logic   stall_on;  // random cen drops in the second pass
    logic   took_cen;  // cen was high at the last edge
    int     n_reads;

    mem_subsys #(
        .addr_bits (10)
    ) mem_subsys_i (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .ldram_en (ldram_en),
        .idx_addr (idx_addr),
        .xsp      (xsp),
        .pc       (pc),
        .sel_xsp  (sel_xsp),
        .data_sel (data_sel),
        .alu_dout (alu_dout),
        .idx_wr   (idx_wr),
        .len      (len),
        .dout     (dout),
        .ram_rdy  (ram_rdy)
    );

    always #5 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input long_t actual, input long_t expected, input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns: %s returned %h, expected %h",
                     $time, what, actual, expected);
            $display("Test failed");
            $fatal(1, "read data mismatch");
        end
    endtask

    // one clock edge, then choose cen for the coming cycle
    task automatic step_cycle();
        @(posedge clk);
        took_cen = cen;  // value the DUT saw at this edge
        if (stall_on) begin
            cen <= ($random(seed) & 3) != 0;  // roughly one stall in four
        end else begin
            cen <= 1'b1;
        end
    endtask

    task automatic reset_dut();
        rst <= 1'b1;
        cen <= 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic wait_ready(input string what);
        int n;
        n = 0;
        step_cycle();
        while (!ram_rdy) begin
            n++;
            if (n > wait_limit) begin
                abort_run($sformatf("ram_rdy never rose within %0d cycles during %s",
                                    wait_limit, what));
            end
            step_cycle();
        end
    endtask

    // store, then wait until the window refills at the current request
    task automatic issue_store(input addr_t addr, input long_t data, input size_t size,
                               input logic use_xsp, input logic use_pc);
        int n;
        if (use_xsp) begin
            xsp <= addr;
        end else begin
            idx_addr <= addr;
        end
        if (use_pc) begin
            pc       <= data[23:0];
            alu_dout <= ~data;  // alu value differs from pc
        end else begin
            alu_dout <= data;
        end
        sel_xsp  <= use_xsp;
        data_sel <= use_pc;
        len      <= size;
        idx_wr   <= 1'b1;
        n = 0;
        step_cycle();
        while (!took_cen) begin
            n++;
            if (n > wait_limit) begin
                abort_run("the store strobe was never taken because cen stayed low");
            end
            step_cycle();
        end
        idx_wr <= 1'b0;  // inputs stay put until the store is over
        wait_ready("store");
    endtask

    task automatic read_and_check(input logic from_idx, input addr_t addr,
                                  input long_t expected);
        ldram_en <= from_idx;
        if (from_idx) begin
            idx_addr <= addr;
        end else begin
            pc <= addr;
        end
        wait_ready(from_idx ? "data read" : "fetch");
        n_reads++;
        check_value(dout, expected,
                    $sformatf("%s at %h", from_idx ? "data read" : "fetch", addr));
    endtask

    task automatic run_stim();
        int    fd;
        int    code;
        int    line_no;
        string line;
        byte   op;
        addr_t addr;
        long_t data;
        size_t size;
        logic  f_xsp;
        logic  f_pc;
        long_t expected;
        fd = $fopen("verif/mem_subsys_stim.txt", "r");
        if (fd == 0) begin
            abort_run("could not open verif/mem_subsys_stim.txt");
        end
        line_no = 0;
        while ($fgets(line, fd) != 0) begin
            line_no++;
            if (line.len() < 2 || line[0] == "#") begin
                continue;  // blank or column notes
            end
            code = $sscanf(line, "%c %h %h %h %h %h %h",
                           op, addr, data, size, f_xsp, f_pc, expected);
            if (code != 7) begin
                abort_run($sformatf("stim line %0d is malformed", line_no));
            end
            case (op)
                "W": issue_store(addr, data, size, f_xsp, f_pc);
                "R": read_and_check(1'b1, addr, expected);
                "F": read_and_check(1'b0, addr, expected);
                default: abort_run($sformatf("unknown opcode on stim line %0d", line_no));
            endcase
        end
        $fclose(fd);
    endtask

    initial begin
        seed     = 32'h7de6_5a90;
        clk      = 1'b0;
        rst      = 1'b1;
        cen      = 1'b1;
        ldram_en = 1'b0;
        idx_addr = '0;
        xsp      = '0;
        pc       = '0;
        sel_xsp  = 1'b0;
        data_sel = 1'b0;
        alu_dout = '0;
        idx_wr   = 1'b0;
        len      = 3'b001;
        stall_on = 1'b0;
        took_cen = 1'b0;
        n_reads  = 0;

        reset_dut();
        run_stim();
        stall_on = 1'b1;  // same sequence again, now with stalls
        reset_dut();
        run_stim();

        if (n_reads > 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("the stim file held no reads to check");
            $display("Test failed");
            $fatal(1, "nothing checked");
        end
    end

endmodule
